// ==== common/cachePkg.sv ====
`default_nettype none

package cachePkg;

	// address split of a request
	localparam int TAG_WIDTH = 8;
	localparam int INDEX_WIDTH = 4;
	localparam int NUM_SETS = 1 << INDEX_WIDTH;

	typedef logic [TAG_WIDTH - 1 : 0] tagT;
	typedef logic [INDEX_WIDTH - 1 : 0] indexT;

	// line state as stored next to each tag
	typedef logic [1 : 0] lineStateT;

	localparam lineStateT LINE_INVALID = 2'd0;
	localparam lineStateT LINE_CLEAN = 2'd1;
	localparam lineStateT LINE_DIRTY = 2'd2;

	// request operation codes
	typedef logic [1 : 0] opT;

	localparam opT OP_READ = 2'd0;
	localparam opT OP_WRITE = 2'd1;
	localparam opT OP_INVALIDATE = 2'd2;

	// controller FSM states
	typedef enum logic [2 : 0] {
		IDLE,
		LOOKUP,
		ALLOCATE,
		UPDATE,
		RESPOND
	} ctrlStateT;

endpackage : cachePkg

`default_nettype wire

// ==== dv/tagSubsystemTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module tagSubsystemTb;

	import cachePkg::*;

	localparam int WAY_BITS = 2;
	localparam int CREDITS = 2;
	localparam int NUM_WAYS = 1 << WAY_BITS;
	localparam int NUM_DIRECTED = 14;
	localparam int NUM_RANDOM = 300;
	localparam int NUM_REQUESTS = NUM_DIRECTED + NUM_RANDOM;
	localparam int TIMEOUT_CYCLES = 6 * NUM_REQUESTS + 200;

	typedef logic [WAY_BITS - 1 : 0] wayT;

	typedef struct packed {
		logic hit;
		wayT way;
		tagT victimTag;
		lineStateT victimState;
	} responseT;

	logic clock;
	logic rst;
	logic reqValid;
	opT reqOp;
	indexT reqIndex;
	tagT reqTag;
	logic rspValid;
	logic rspHit;
	wayT rspWay;
	tagT rspVictimTag;
	lineStateT rspVictimState;
	logic creditReturn;

	// reference copy of the tag array and the round-robin pointers
	tagT modelTag [NUM_SETS][NUM_WAYS];
	lineStateT modelState [NUM_SETS][NUM_WAYS];
	wayT modelCounter [NUM_SETS];

	responseT expectedQ [$];
	logic [31:0] seed;
	int issued;
	int returned;
	int responses;
	int checks;
	int errors;
	int cycles;

	tagSubsystemTop #(.WAY_BITS(WAY_BITS), .CREDITS(CREDITS)) uut (
		.clock(clock),
		.rst(rst),
		.reqValid(reqValid),
		.reqOp(reqOp),
		.reqIndex(reqIndex),
		.reqTag(reqTag),
		.rspValid(rspValid),
		.rspHit(rspHit),
		.rspWay(rspWay),
		.rspVictimTag(rspVictimTag),
		.rspVictimState(rspVictimState),
		.creditReturn(creditReturn)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [31:0] nextRandom();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	// applies one request to the model and returns what the DUT should answer
	function automatic responseT predictResponse(input opT op, input indexT index, input tagT tag);
		responseT rsp;
		logic found;
		int hitIndex;
		found = 1'b0;
		hitIndex = 0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (modelState[index][w] != LINE_INVALID && modelTag[index][w] == tag) begin
				found = 1'b1;
				hitIndex = w;
			end
		end
		if (found) begin
			rsp.hit = 1'b1;
			rsp.way = wayT'(hitIndex);
			rsp.victimTag = tag;
			rsp.victimState = modelState[index][rsp.way];
			if (op == OP_WRITE) begin
				modelState[index][rsp.way] = LINE_DIRTY;
			end else if (op == OP_INVALIDATE) begin
				modelState[index][rsp.way] = LINE_INVALID;
			end
		end else begin
			rsp.hit = 1'b0;
			rsp.way = modelCounter[index];
			rsp.victimTag = modelTag[index][rsp.way];
			rsp.victimState = modelState[index][rsp.way];
			// invalidate misses leave the set and its pointer alone
			if (op != OP_INVALIDATE) begin
				modelTag[index][rsp.way] = tag;
				modelState[index][rsp.way] = (op == OP_WRITE) ? LINE_DIRTY : LINE_CLEAN;
				modelCounter[index] = modelCounter[index] + 1'b1;
			end
		end
		return rsp;
	endfunction

	task automatic checkTag(input tagT got, input tagT expected, input string what);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	task automatic checkState(input lineStateT got, input lineStateT expected, input string what);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic checkHit(input logic got, input logic expected, input string what);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("error at %0t ns: %s is %b, expected %b", $time, what, got, expected);
		end
	endtask

	task automatic checkWay(input wayT got, input wayT expected, input string what);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	// spends a credit, waiting on the edge until one is free
	task automatic sendRequest(input opT op, input indexT index, input tagT tag);
		@(posedge clock);
		while (issued - returned >= CREDITS) begin
			reqValid <= 1'b0;
			@(posedge clock);
		end
		reqValid <= 1'b1;
		reqOp <= op;
		reqIndex <= index;
		reqTag <= tag;
		issued++;
		expectedQ.push_back(predictResponse(op, index, tag));
	endtask

	task automatic waitForResponses();
		@(posedge clock);
		reqValid <= 1'b0;
		while (returned != issued) begin
			@(posedge clock);
		end
	endtask

	// responses are sampled half a cycle after they change
	always @(negedge clock) begin : compareResponses
		responseT expectedRsp;
		if (!rst) begin
			if (rspValid !== creditReturn) begin
				errors++;
				$display("response valid and credit return disagree at %0t ns", $time);
			end
			if (creditReturn === 1'b1) begin
				returned++;
			end
			if (rspValid === 1'b1) begin
				if (expectedQ.size() == 0) begin
					errors++;
					$display("a response came with no request outstanding at %0t ns", $time);
				end else begin
					expectedRsp = expectedQ.pop_front();
					responses++;
					checkHit(rspHit, expectedRsp.hit, "hit");
					checkWay(rspWay, expectedRsp.way, "way");
					checkState(rspVictimState, expectedRsp.victimState, "victim state");
					// an invalid line's tag is stale or was never written
					if (expectedRsp.victimState != LINE_INVALID) begin
						checkTag(rspVictimTag, expectedRsp.victimTag, "victim tag");
					end
				end
			end
		end
	end

	always @(posedge clock) begin : watchdog
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, %0d of %0d requests answered",
				cycles, responses, NUM_REQUESTS);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin : stimulus
		logic [31:0] r;
		for (int s = 0; s < NUM_SETS; s++) begin
			modelCounter[s] = '0;
			for (int w = 0; w < NUM_WAYS; w++) begin
				modelTag[s][w] = '0;
				modelState[s][w] = LINE_INVALID;
			end
		end
		seed = 32'd8;
		issued = 0;
		returned = 0;
		responses = 0;
		checks = 0;
		errors = 0;
		cycles = 0;
		rst = 1'b1;
		reqValid = 1'b0;
		reqOp = OP_READ;
		reqIndex = '0;
		reqTag = '0;
		repeat (3) @(posedge clock);
		rst <= 1'b0;

		// cold misses land in way 0
		sendRequest(OP_READ, 4'd3, 8'h11);
		sendRequest(OP_READ, 4'd9, 8'ha5);
		waitForResponses();

		// clean hit, write hit, then a read sees the dirty line
		sendRequest(OP_READ, 4'd3, 8'h11);
		sendRequest(OP_WRITE, 4'd3, 8'h11);
		sendRequest(OP_READ, 4'd3, 8'h11);
		waitForResponses();

		// five tags in set 5 wrap the pointer back to way 0
		sendRequest(OP_WRITE, 4'd5, 8'h20);
		for (int t = 1; t < 5; t++) begin
			sendRequest(OP_READ, 4'd5, tagT'(8'h20 + t));
		end
		waitForResponses();

		// invalidate hit, re-read misses, invalidate miss keeps the order
		sendRequest(OP_INVALIDATE, 4'd5, 8'h22);
		sendRequest(OP_READ, 4'd5, 8'h22);
		sendRequest(OP_INVALIDATE, 4'd5, 8'h77);
		sendRequest(OP_READ, 4'd5, 8'h30);
		waitForResponses();

		// few sets and tags so hits, misses and evictions all occur
		for (int n = 0; n < NUM_RANDOM; n++) begin
			r = nextRandom();
			sendRequest(opT'(int'(r[31:28]) % 3), indexT'(r[25:24]), tagT'(r[18:16]));
		end
		waitForResponses();
		repeat (10) @(posedge clock);

		if (expectedQ.size() != 0 || responses != NUM_REQUESTS) begin
			errors++;
			$display("only %0d of %0d requests were answered", responses, NUM_REQUESTS);
		end
		$display("requests %0d, responses %0d, checks %0d, errors %0d",
			issued, responses, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule : tagSubsystemTb

`default_nettype wire

// ==== rtl/cacheController.sv ====
`timescale 1ns/100ps
`default_nettype none

module cacheController #(
	parameter int WAY_BITS = 2
) (
	input logic clock,
	input logic rst,
	input logic qValid,
	input cachePkg::opT qOp,
	input cachePkg::indexT qIndex,
	input cachePkg::tagT qTag,
	output logic qPop,
	input logic hit,
	input logic [WAY_BITS - 1 : 0] hitWay,
	input cachePkg::tagT tagOut,
	input cachePkg::lineStateT stateOut,
	input logic [WAY_BITS - 1 : 0] victimWay,
	output cachePkg::indexT lookupIndex,
	output cachePkg::tagT tagIn,
	output cachePkg::lineStateT stateIn,
	output logic writeTag,
	output logic writeState,
	output logic [WAY_BITS - 1 : 0] writeWay,
	output logic [WAY_BITS - 1 : 0] readWay,
	output cachePkg::indexT counterIndex,
	output logic advance,
	output logic rspValid,
	output logic rspHit,
	output logic [WAY_BITS - 1 : 0] rspWay,
	output cachePkg::tagT rspVictimTag,
	output cachePkg::lineStateT rspVictimState,
	output logic creditReturn
);

	import cachePkg::*;

	ctrlStateT state;
	ctrlStateT nextState;

	// request being served
	opT opReg;
	indexT indexReg;
	tagT tagReg;

	// lookup result
	logic hitReg;
	logic [WAY_BITS - 1 : 0] wayReg;
	tagT victimTagReg;
	lineStateT victimStateReg;

	logic needsAllocate;

	assign qPop = (state == IDLE) && qValid;

	// invalidates never allocate on a miss
	assign needsAllocate = !hit && (opReg != OP_INVALIDATE);

	always_comb begin
		nextState = state;
		case (state)
			IDLE: if (qValid) nextState = LOOKUP;
			LOOKUP: nextState = needsAllocate ? ALLOCATE : UPDATE;
			ALLOCATE: nextState = RESPOND;
			UPDATE: nextState = RESPOND;
			RESPOND: nextState = IDLE;
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge clock) begin
		if (qPop) begin
			opReg <= qOp;
			indexReg <= qIndex;
			tagReg <= qTag;
		end
		if (state == LOOKUP) begin
			hitReg <= hit;
			wayReg <= hit ? hitWay : victimWay;
			// tag memory shows the victim way's contents on a miss
			victimTagReg <= tagOut;
			victimStateReg <= stateOut;
		end
	end

	// tag memory and counter are always addressed by the latched request
	assign lookupIndex = indexReg;
	assign counterIndex = indexReg;
	assign tagIn = tagReg;
	assign readWay = victimWay;
	assign writeWay = wayReg;

	// state to write, used by both ALLOCATE and UPDATE
	always_comb begin
		case (opReg)
			OP_WRITE: stateIn = LINE_DIRTY;
			OP_INVALIDATE: stateIn = LINE_INVALID;
			default: stateIn = LINE_CLEAN;
		endcase
	end

	assign writeTag = (state == ALLOCATE);
	assign advance = (state == ALLOCATE);

	// read hits and invalidate misses pass UPDATE without writing
	assign writeState = (state == ALLOCATE) ||
		((state == UPDATE) && hitReg && (opReg != OP_READ));

	assign rspValid = (state == RESPOND);
	assign creditReturn = (state == RESPOND);
	assign rspHit = hitReg;
	assign rspWay = wayReg;
	assign rspVictimTag = victimTagReg;
	assign rspVictimState = victimStateReg;

	// a hit response always names a valid line
	assert property (@(posedge clock) disable iff (rst)
		rspValid && rspHit |-> rspVictimState != LINE_INVALID)
		else $error("hit response reports an invalid line");

endmodule : cacheController

`default_nettype wire

// ==== rtl/replacementCounter.sv ====
`timescale 1ns/100ps
`default_nettype none

module replacementCounter #(
	parameter int WAY_BITS = 2
) (
	input logic clock,
	input logic rst,
	input cachePkg::indexT counterIndex,
	input logic advance,
	output logic [WAY_BITS - 1 : 0] victimWay
);

	import cachePkg::*;

	// one round-robin pointer per set
	logic [WAY_BITS - 1 : 0] counters [NUM_SETS];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < NUM_SETS; i++) begin
				counters[i] <= '0;
			end
		end else if (advance) begin
			// wraps to way 0 past the last way
			counters[counterIndex] <= counters[counterIndex] + 1'b1;
		end
	end

	assign victimWay = counters[counterIndex];

endmodule : replacementCounter

`default_nettype wire

// ==== rtl/requestQueue.sv ====
`timescale 1ns/100ps
`default_nettype none

module requestQueue #(
	parameter int CREDITS = 2
) (
	input logic clock,
	input logic rst,
	input logic reqValid,
	input cachePkg::opT reqOp,
	input cachePkg::indexT reqIndex,
	input cachePkg::tagT reqTag,
	input logic qPop,
	output logic qValid,
	output cachePkg::opT qOp,
	output cachePkg::indexT qIndex,
	output cachePkg::tagT qTag
);

	import cachePkg::*;

	localparam int PTR_BITS = (CREDITS > 1) ? $clog2(CREDITS) : 1;
	localparam int COUNT_BITS = $clog2(CREDITS + 1);

	opT opMem [CREDITS];
	indexT indexMem [CREDITS];
	tagT tagMem [CREDITS];

	logic [PTR_BITS - 1 : 0] writePtr;
	logic [PTR_BITS - 1 : 0] readPtr;
	logic [COUNT_BITS - 1 : 0] count;

	// pointers wrap at the depth, which need not be a power of two
	function automatic logic [PTR_BITS - 1 : 0] nextPtr(input logic [PTR_BITS - 1 : 0] ptr);
		if (ptr == PTR_BITS'(CREDITS - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// payload storage
	always_ff @(posedge clock) begin
		if (reqValid) begin
			opMem[writePtr] <= reqOp;
			indexMem[writePtr] <= reqIndex;
			tagMem[writePtr] <= reqTag;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			writePtr <= '0;
			readPtr <= '0;
			count <= '0;
		end else begin
			if (reqValid) begin
				writePtr <= nextPtr(writePtr);
			end
			if (qPop) begin
				readPtr <= nextPtr(readPtr);
			end
			case ({reqValid, qPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign qValid = (count != '0);
	assign qOp = opMem[readPtr];
	assign qIndex = indexMem[readPtr];
	assign qTag = tagMem[readPtr];

	// requester pushed without holding a credit
	assert property (@(posedge clock) disable iff (rst) reqValid |-> count != COUNT_BITS'(CREDITS))
		else $error("request pushed into a full queue");

	assert property (@(posedge clock) disable iff (rst) qPop |-> qValid)
		else $error("pop from an empty queue");

endmodule : requestQueue

`default_nettype wire

// ==== rtl/tagSubsystemTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module tagSubsystemTop #(
	parameter int WAY_BITS = 2,
	parameter int CREDITS = 2
) (
	input logic clock,
	input logic rst,
	input logic reqValid,
	input cachePkg::opT reqOp,
	input cachePkg::indexT reqIndex,
	input cachePkg::tagT reqTag,
	output logic rspValid,
	output logic rspHit,
	output logic [WAY_BITS - 1 : 0] rspWay,
	output cachePkg::tagT rspVictimTag,
	output cachePkg::lineStateT rspVictimState,
	output logic creditReturn
);

	import cachePkg::*;

	// queue to controller
	logic qValid;
	logic qPop;
	opT qOp;
	indexT qIndex;
	tagT qTag;

	// controller to tag memory
	indexT lookupIndex;
	tagT tagIn;
	lineStateT stateIn;
	logic writeTag;
	logic writeState;
	logic [WAY_BITS - 1 : 0] writeWay;
	logic [WAY_BITS - 1 : 0] readWay;

	// tag memory to controller
	logic hit;
	logic [WAY_BITS - 1 : 0] hitWay;
	tagT tagOut;
	lineStateT stateOut;

	// replacement
	indexT counterIndex;
	logic advance;
	logic [WAY_BITS - 1 : 0] victimWay;

	requestQueue #(.CREDITS(CREDITS)) queue (
		.clock(clock), .rst(rst),
		.reqValid(reqValid), .reqOp(reqOp), .reqIndex(reqIndex), .reqTag(reqTag),
		.qPop(qPop),
		.qValid(qValid), .qOp(qOp), .qIndex(qIndex), .qTag(qTag)
	);

	cacheController #(.WAY_BITS(WAY_BITS)) controller (
		.clock(clock), .rst(rst),
		.qValid(qValid), .qOp(qOp), .qIndex(qIndex), .qTag(qTag), .qPop(qPop),
		.hit(hit), .hitWay(hitWay), .tagOut(tagOut), .stateOut(stateOut),
		.victimWay(victimWay),
		.lookupIndex(lookupIndex), .tagIn(tagIn), .stateIn(stateIn),
		.writeTag(writeTag), .writeState(writeState),
		.writeWay(writeWay), .readWay(readWay),
		.counterIndex(counterIndex), .advance(advance),
		.rspValid(rspValid), .rspHit(rspHit), .rspWay(rspWay),
		.rspVictimTag(rspVictimTag), .rspVictimState(rspVictimState),
		.creditReturn(creditReturn)
	);

	replacementCounter #(.WAY_BITS(WAY_BITS)) replacement (
		.clock(clock), .rst(rst),
		.counterIndex(counterIndex), .advance(advance), .victimWay(victimWay)
	);

	setAssociativeTagMemory #(.WAY_BITS(WAY_BITS)) tagMemory (
		.clock(clock), .rst(rst),
		.lookupIndex(lookupIndex), .tagIn(tagIn), .stateIn(stateIn),
		.writeTag(writeTag), .writeState(writeState),
		.writeWay(writeWay), .readWay(readWay),
		.hit(hit), .hitWay(hitWay), .tagOut(tagOut), .stateOut(stateOut)
	);

endmodule : tagSubsystemTop

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the tag subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir

verilator --binary --timing --assert -f sim.f --top-module tagSubsystemTb -o tagSubsystemSim

./obj_dir/tagSubsystemSim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation finished without failures"

// ==== sim.f ====
common/cachePkg.sv
tagMemory/tagWay.sv
tagMemory/setAssociativeTagMemory.sv
rtl/requestQueue.sv
rtl/replacementCounter.sv
rtl/cacheController.sv
rtl/tagSubsystemTop.sv
dv/tagSubsystemTb.sv

// ==== tagMemory/setAssociativeTagMemory.sv ====
`timescale 1ns/100ps
`default_nettype none

module setAssociativeTagMemory #(
	parameter int WAY_BITS = 2
) (
	input logic clock,
	input logic rst,
	input cachePkg::indexT lookupIndex,
	input cachePkg::tagT tagIn,
	input cachePkg::lineStateT stateIn,
	input logic writeTag,
	input logic writeState,
	input logic [WAY_BITS - 1 : 0] writeWay,
	input logic [WAY_BITS - 1 : 0] readWay,
	output logic hit,
	output logic [WAY_BITS - 1 : 0] hitWay,
	output cachePkg::tagT tagOut,
	output cachePkg::lineStateT stateOut
);

	import cachePkg::*;

	localparam int NUM_WAYS = 1 << WAY_BITS;

	logic [NUM_WAYS - 1 : 0] wayHit;
	logic [NUM_WAYS - 1 : 0] wayWriteTag;
	logic [NUM_WAYS - 1 : 0] wayWriteState;
	tagT wayTag [NUM_WAYS];
	lineStateT wayState [NUM_WAYS];
	logic [WAY_BITS - 1 : 0] selectedWay;

	// index, tag and state go to every way alike
	for (genvar i = 0; i < NUM_WAYS; i++) begin : ways
		tagWay way (
			.clock(clock),
			.rst(rst),
			.index(lookupIndex),
			.tagIn(tagIn),
			.stateIn(stateIn),
			.writeTag(wayWriteTag[i]),
			.writeState(wayWriteState[i]),
			.hit(wayHit[i]),
			.tagOut(wayTag[i]),
			.stateOut(wayState[i])
		);
	end

	// write strobe demultiplexers
	always_comb begin
		wayWriteTag = '0;
		wayWriteState = '0;
		wayWriteTag[writeWay] = writeTag;
		wayWriteState[writeWay] = writeState;
	end

	assign hit = |wayHit;

	// number of the hitting way, zero when nothing hits
	always_comb begin
		hitWay = '0;
		for (int i = 0; i < NUM_WAYS; i++) begin
			if (wayHit[i]) begin
				hitWay = WAY_BITS'(i);
			end
		end
	end

	// on a miss the caller picks which way to look at
	assign selectedWay = hit ? hitWay : readWay;

	// output multiplexers
	assign tagOut = wayTag[selectedWay];
	assign stateOut = wayState[selectedWay];

	// a tag lives in at most one way of a set, so allocation must only follow a miss
	assert property (@(posedge clock) disable iff (rst) $onehot0(wayHit))
		else $error("tag present in more than one way of set %0d", lookupIndex);

endmodule : setAssociativeTagMemory

`default_nettype wire

// ==== tagMemory/tagWay.sv ====
`timescale 1ns/100ps
`default_nettype none

module tagWay (
	input logic clock,
	input logic rst,
	input cachePkg::indexT index,
	input cachePkg::tagT tagIn,
	input cachePkg::lineStateT stateIn,
	input logic writeTag,
	input logic writeState,
	output logic hit,
	output cachePkg::tagT tagOut,
	output cachePkg::lineStateT stateOut
);

	import cachePkg::*;

	// one entry per set
	tagT tags [NUM_SETS];
	lineStateT states [NUM_SETS];

	// tag storage, meaningless until the state says otherwise
	always_ff @(posedge clock) begin
		if (writeTag) begin
			tags[index] <= tagIn;
		end
	end

	// all lines start out invalid
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < NUM_SETS; i++) begin
				states[i] <= LINE_INVALID;
			end
		end else if (writeState) begin
			states[index] <= stateIn;
		end
	end

	// lookup is purely combinational
	assign tagOut = tags[index];
	assign stateOut = states[index];

	// an invalid line never hits, whatever its stale tag holds
	assign hit = (stateOut != LINE_INVALID) && (tagOut == tagIn);

endmodule : tagWay

`default_nettype wire
